// File: src/frontend_pkg.sv
package frontend_pkg;

  // ====================
  // sizes
  // ====================
  localparam int XLEN            = 32;
  localparam int INST_BYTES      = 4;
  localparam int IBUF_DEPTH      = 4;
  localparam int IBUF_PTR_W      = $clog2(IBUF_DEPTH);
  localparam int IBUF_CNT_W      = 3;   // holds 0..IBUF_DEPTH and inflight+occupancy
  localparam int MAX_OUTSTANDING = 2;
  localparam int OUTS_PTR_W      = $clog2(MAX_OUTSTANDING);

  localparam logic [XLEN-1:0] PC_RESET = 32'h0000_1000;

  // axi encodings
  localparam logic [2:0] AR_PROT_INST = 3'b100;  // unprivileged, secure, instruction
  localparam logic [1:0] RESP_OKAY    = 2'b00;

  // ====================
  // enums
  // ====================
  typedef enum logic [1:0] {
    NONE         = 2'd0,
    SILENT_FLUSH = 2'd1,
    XRET         = 2'd2,
    EXCEPTION    = 2'd3
  } commit_kind_e;

  typedef enum logic {
    MRET = 1'b0,
    SRET = 1'b1
  } xret_e;

  typedef enum logic [1:0] {
    INIT            = 2'd0,
    FETCH_REQ       = 2'd1,
    WAIT_IBUF_FREE  = 2'd2,
    WAIT_FLUSH_FREE = 2'd3
  } fetch_state_e;

  // ====================
  // structs
  // ====================
  typedef struct packed {
    logic            valid;
    commit_kind_e    kind;
    xret_e           xret;
    logic [3:0]      cause;   // mcause exception code
    logic [XLEN-1:0] epc;
  } commit_t;

  typedef struct packed {
    logic            valid;
    logic            mispredict;
    logic [XLEN-1:0] target;
  } br_upd_t;

  typedef struct packed {
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] sepc;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] stvec;
    logic [15:0]     medeleg;
  } csr_vec_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
  } redirect_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    logic            fault;   // access fault on the read
  } fetch_word_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [2:0]      prot;
  } axi_ar_t;

  typedef struct packed {
    logic [XLEN-1:0] data;
    logic [1:0]      resp;
  } axi_r_t;

endpackage

// File: src/redirect_target.sv
module redirect_target (
  input  frontend_pkg::commit_t   i_commit,
  input  frontend_pkg::br_upd_t   i_br_upd,
  input  frontend_pkg::csr_vec_t  i_csr,
  output frontend_pkg::redirect_t o_redirect
);

  logic                          w_commit_flush;
  logic                          w_br_flush;
  logic                          w_delegated;
  logic [frontend_pkg::XLEN-1:0] w_trap_vec;
  logic [frontend_pkg::XLEN-1:0] w_xret_pc;
  logic [frontend_pkg::XLEN-1:0] w_target;

  // ====================
  // redirect sources
  // ====================
  assign w_commit_flush = i_commit.valid && (i_commit.kind != frontend_pkg::NONE);
  assign w_br_flush     = i_br_upd.valid && i_br_upd.mispredict;

  // exception goes to S-mode when its cause is delegated
  assign w_delegated = i_csr.medeleg[i_commit.cause];
  assign w_trap_vec  = w_delegated ? i_csr.stvec : i_csr.mtvec;

  assign w_xret_pc = (i_commit.xret == frontend_pkg::MRET) ? i_csr.mepc : i_csr.sepc;

  // ====================
  // target select
  // ====================
  // commit has priority over a branch in the same cycle
  always_comb begin
    w_target = '0;
    if (w_commit_flush) begin
      case (i_commit.kind)
        frontend_pkg::SILENT_FLUSH: begin
          w_target = i_commit.epc + frontend_pkg::INST_BYTES;  // resume after the flushing inst
        end
        frontend_pkg::XRET: begin
          w_target = w_xret_pc;
        end
        frontend_pkg::EXCEPTION: begin
          w_target = w_trap_vec;
        end
        default: begin
          w_target = '0;
        end
      endcase
    end else if (w_br_flush) begin
      w_target = i_br_upd.target;
    end
  end

  assign o_redirect.valid = w_commit_flush | w_br_flush;
  // word aligned, also strips the tvec mode bits
  assign o_redirect.pc    = {w_target[frontend_pkg::XLEN-1:2], 2'b00};

endmodule

// File: src/fetch_pc_ctrl.sv
module fetch_pc_ctrl (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  frontend_pkg::redirect_t             i_redirect,
  input  logic [frontend_pkg::IBUF_CNT_W-1:0] i_inflight,
  input  logic [frontend_pkg::IBUF_CNT_W-1:0] i_ibuf_count,
  input  logic                                i_ar_accept,
  output logic                                o_issue_valid,
  output logic [frontend_pkg::XLEN-1:0]       o_issue_addr
);

  frontend_pkg::fetch_state_e r_state;
  frontend_pkg::fetch_state_e w_state_next;

  logic [frontend_pkg::XLEN-1:0]     r_pc;
  logic [frontend_pkg::XLEN-1:0]     w_pc_next;
  logic [frontend_pkg::XLEN-1:0]     r_redir_pc;  // target parked behind a pending AR
  logic                              r_ar_pending;
  logic [frontend_pkg::IBUF_CNT_W:0] w_reserved;
  logic                              w_credit_ok;
  logic                              w_slot_free;
  logic                              w_active;
  logic                              w_fire;

  // ====================
  // issue decision
  // ====================
  // every read in flight will claim a buffer entry
  assign w_reserved  = i_inflight + i_ibuf_count;
  assign w_credit_ok = (w_reserved < frontend_pkg::IBUF_DEPTH) &&
                       (i_inflight < frontend_pkg::MAX_OUTSTANDING);
  assign w_slot_free = !r_ar_pending || i_ar_accept;  // AR register frees up this cycle
  assign w_active    = (r_state == frontend_pkg::FETCH_REQ) ||
                       (r_state == frontend_pkg::WAIT_IBUF_FREE);
  assign w_fire      = w_active && w_credit_ok && w_slot_free && !i_redirect.valid;

  assign o_issue_valid = w_fire;
  assign o_issue_addr  = r_pc;

  // ====================
  // state machine
  // ====================
  always_comb begin
    w_state_next = r_state;
    w_pc_next    = w_fire ? r_pc + frontend_pkg::INST_BYTES : r_pc;
    if (i_redirect.valid) begin
      if (r_ar_pending && !i_ar_accept) begin
        w_state_next = frontend_pkg::WAIT_FLUSH_FREE;  // old AR can't be withdrawn
      end else begin
        w_state_next = frontend_pkg::FETCH_REQ;
        w_pc_next    = i_redirect.pc;
      end
    end else begin
      case (r_state)
        frontend_pkg::INIT: begin
          w_state_next = frontend_pkg::FETCH_REQ;
        end
        frontend_pkg::FETCH_REQ, frontend_pkg::WAIT_IBUF_FREE: begin
          w_state_next = w_credit_ok ? frontend_pkg::FETCH_REQ : frontend_pkg::WAIT_IBUF_FREE;
        end
        frontend_pkg::WAIT_FLUSH_FREE: begin
          if (i_ar_accept) begin
            w_state_next = frontend_pkg::FETCH_REQ;
            w_pc_next    = r_redir_pc;
          end
        end
        default: begin
          w_state_next = frontend_pkg::INIT;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state      <= frontend_pkg::INIT;
      r_pc         <= frontend_pkg::PC_RESET;
      r_ar_pending <= 1'b0;
    end else begin
      r_state      <= w_state_next;
      r_pc         <= w_pc_next;
      r_ar_pending <= w_fire || (r_ar_pending && !i_ar_accept);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_redirect.valid) begin
      r_redir_pc <= i_redirect.pc;
    end
  end

endmodule

// File: src/fetch_axi_master.sv
module fetch_axi_master (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  frontend_pkg::redirect_t             i_redirect,
  input  logic                                i_issue_valid,
  input  logic [frontend_pkg::XLEN-1:0]       i_issue_addr,
  output logic                                o_ar_accept,
  output logic [frontend_pkg::IBUF_CNT_W-1:0] o_inflight,
  output logic                                o_arvalid,
  output frontend_pkg::axi_ar_t               o_ar,
  input  logic                                i_arready,
  input  logic                                i_rvalid,
  input  frontend_pkg::axi_r_t                i_r,
  output logic                                o_rready,
  output logic                                o_push_valid,
  output frontend_pkg::fetch_word_t           o_push
);

  logic                                r_arvalid;
  logic [frontend_pkg::XLEN-1:0]       r_ar_addr;
  logic                                r_ar_stale;  // pending AR overtaken by a redirect
  logic [frontend_pkg::XLEN-1:0]       r_pc_q [frontend_pkg::MAX_OUTSTANDING];
  logic [frontend_pkg::OUTS_PTR_W-1:0] r_q_wptr;
  logic [frontend_pkg::OUTS_PTR_W-1:0] r_q_rptr;
  logic [frontend_pkg::IBUF_CNT_W-1:0] r_inflight;   // accepted, no response yet
  logic [frontend_pkg::IBUF_CNT_W-1:0] w_inflight_next;
  logic [frontend_pkg::IBUF_CNT_W-1:0] r_drop;
  logic [frontend_pkg::IBUF_CNT_W-1:0] w_drop_next;
  logic                                w_ar_hs;
  logic                                w_r_hs;
  logic                                w_drop_resp;

  // ====================
  // AR channel
  // ====================
  assign w_ar_hs = r_arvalid & i_arready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_arvalid  <= 1'b0;
      r_ar_stale <= 1'b0;
    end else begin
      if (i_issue_valid) begin
        r_arvalid <= 1'b1;
      end else if (w_ar_hs) begin
        r_arvalid <= 1'b0;
      end
      if (i_issue_valid || w_ar_hs) begin
        r_ar_stale <= 1'b0;
      end else if (i_redirect.valid && r_arvalid) begin
        r_ar_stale <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_issue_valid) begin
      r_ar_addr <= i_issue_addr;
    end
  end

  assign o_arvalid   = r_arvalid;
  assign o_ar.addr   = r_ar_addr;
  assign o_ar.prot   = frontend_pkg::AR_PROT_INST;
  assign o_ar_accept = w_ar_hs;
  assign o_inflight  = r_inflight + r_arvalid;  // pending AR counts too

  // ====================
  // R channel
  // ====================
  assign o_rready    = 1'b1;
  assign w_r_hs      = i_rvalid & o_rready;
  assign w_drop_resp = w_r_hs & (r_drop != '0);  // stale reads always come back first

  assign o_push_valid = w_r_hs & !w_drop_resp & !i_redirect.valid;
  assign o_push.pc    = r_pc_q[r_q_rptr];
  assign o_push.inst  = i_r.data;
  assign o_push.fault = (i_r.resp != frontend_pkg::RESP_OKAY);

  always_comb begin
    w_inflight_next = r_inflight + w_ar_hs - w_r_hs;
    if (i_redirect.valid) begin
      w_drop_next = w_inflight_next;  // everything still out is stale
    end else begin
      w_drop_next = r_drop + (w_ar_hs & r_ar_stale) - w_drop_resp;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_q_wptr   <= '0;
      r_q_rptr   <= '0;
      r_inflight <= '0;
      r_drop     <= '0;
    end else begin
      if (w_ar_hs) begin
        r_q_wptr <= r_q_wptr + 1'b1;
      end
      if (w_r_hs) begin
        r_q_rptr <= r_q_rptr + 1'b1;
      end
      r_inflight <= w_inflight_next;
      r_drop     <= w_drop_next;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_ar_hs) begin
      r_pc_q[r_q_wptr] <= r_ar_addr;
    end
  end

endmodule

// File: src/inst_buffer.sv
module inst_buffer (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  frontend_pkg::redirect_t             i_redirect,
  input  logic                                i_push_valid,
  input  frontend_pkg::fetch_word_t           i_push,
  output logic [frontend_pkg::IBUF_CNT_W-1:0] o_count,
  output logic                                o_disp_valid,
  output frontend_pkg::fetch_word_t           o_disp,
  input  logic                                i_disp_ready
);

  frontend_pkg::fetch_word_t           r_mem [frontend_pkg::IBUF_DEPTH];
  logic [frontend_pkg::IBUF_PTR_W-1:0] r_wptr;
  logic [frontend_pkg::IBUF_PTR_W-1:0] r_rptr;
  logic [frontend_pkg::IBUF_CNT_W-1:0] r_count;
  logic                                w_push;
  logic                                w_pop;

  // ====================
  // pointers
  // ====================
  assign w_push = i_push_valid & !i_redirect.valid;  // nothing enters on a flush
  assign w_pop  = o_disp_valid & i_disp_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wptr  <= '0;
      r_rptr  <= '0;
      r_count <= '0;
    end else if (i_redirect.valid) begin
      // a pop this cycle still sees the old head
      r_wptr  <= '0;
      r_rptr  <= '0;
      r_count <= '0;
    end else begin
      if (w_push) begin
        r_wptr <= r_wptr + 1'b1;
      end
      if (w_pop) begin
        r_rptr <= r_rptr + 1'b1;
      end
      r_count <= r_count + w_push - w_pop;
    end
  end

  // ====================
  // storage
  // ====================
  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_mem[r_wptr] <= i_push;
    end
  end

  assign o_count      = r_count;
  assign o_disp_valid = (r_count != '0);
  assign o_disp       = r_mem[r_rptr];  // head stays put while stalled

endmodule

// File: src/frontend_top.sv
module frontend_top (
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  // back end
  input  frontend_pkg::commit_t     i_commit,
  input  frontend_pkg::br_upd_t     i_br_upd,
  input  frontend_pkg::csr_vec_t    i_csr,

  // AXI4-Lite read
  output logic                      o_arvalid,
  output frontend_pkg::axi_ar_t     o_ar,
  input  logic                      i_arready,
  input  logic                      i_rvalid,
  input  frontend_pkg::axi_r_t      i_r,
  output logic                      o_rready,

  // dispatch
  output logic                      o_disp_valid,
  output frontend_pkg::fetch_word_t o_disp,
  input  logic                      i_disp_ready
);

  frontend_pkg::redirect_t             w_redirect;
  logic                                w_issue_valid;
  logic [frontend_pkg::XLEN-1:0]       w_issue_addr;
  logic                                w_ar_accept;
  logic [frontend_pkg::IBUF_CNT_W-1:0] w_inflight;
  logic [frontend_pkg::IBUF_CNT_W-1:0] w_ibuf_count;
  logic                                w_push_valid;
  frontend_pkg::fetch_word_t           w_push;

  redirect_target u_redirect_target (
    .i_commit   (i_commit),
    .i_br_upd   (i_br_upd),
    .i_csr      (i_csr),
    .o_redirect (w_redirect)
  );

  fetch_pc_ctrl u_fetch_pc_ctrl (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_redirect    (w_redirect),
    .i_inflight    (w_inflight),
    .i_ibuf_count  (w_ibuf_count),
    .i_ar_accept   (w_ar_accept),
    .o_issue_valid (w_issue_valid),
    .o_issue_addr  (w_issue_addr)
  );

  fetch_axi_master u_fetch_axi_master (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_redirect    (w_redirect),
    .i_issue_valid (w_issue_valid),
    .i_issue_addr  (w_issue_addr),
    .o_ar_accept   (w_ar_accept),
    .o_inflight    (w_inflight),
    .o_arvalid     (o_arvalid),
    .o_ar          (o_ar),
    .i_arready     (i_arready),
    .i_rvalid      (i_rvalid),
    .i_r           (i_r),
    .o_rready      (o_rready),
    .o_push_valid  (w_push_valid),
    .o_push        (w_push)
  );

  inst_buffer u_inst_buffer (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_redirect   (w_redirect),
    .i_push_valid (w_push_valid),
    .i_push       (w_push),
    .o_count      (w_ibuf_count),
    .o_disp_valid (o_disp_valid),
    .o_disp       (o_disp),
    .i_disp_ready (i_disp_ready)
  );

endmodule

// File: tb/frontend_asserts.sv
module frontend_asserts (
  input logic                                i_clk,
  input logic                                i_reset_n,
  input frontend_pkg::redirect_t             i_redirect,
  input logic                                o_arvalid,
  input frontend_pkg::axi_ar_t               o_ar,
  input logic                                i_arready,
  input logic [frontend_pkg::IBUF_CNT_W-1:0] o_inflight,
  input logic                                o_push_valid
);

  int n_fail = 0;  // read by the testbench top

  // ====================
  // AR channel
  // ====================
  ar_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_arvalid && !i_arready) |=> (o_arvalid && $stable(o_ar)))
    else begin
      n_fail++;
      $error("AR request changed or dropped while waiting for arready");
    end

  inflight_limit: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_inflight <= frontend_pkg::MAX_OUTSTANDING)
    else begin
      n_fail++;
      $error("more reads in flight than allowed: %0d", o_inflight);
    end

  // flush cycle and the two after it only see stale reads come back
  no_push_on_redirect: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_redirect.valid |-> !o_push_valid ##1 !o_push_valid ##1 !o_push_valid)
    else begin
      n_fail++;
      $error("push seen in a redirect cycle or from a read it made stale");
    end

endmodule

bind fetch_axi_master frontend_asserts u_asserts (
  .i_clk        (i_clk),
  .i_reset_n    (i_reset_n),
  .i_redirect   (i_redirect),
  .o_arvalid    (o_arvalid),
  .o_ar         (o_ar),
  .i_arready    (i_arready),
  .o_inflight   (o_inflight),
  .o_push_valid (o_push_valid)
);

// File: tb/frontend_checker.sv
module frontend_checker (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  frontend_pkg::commit_t     i_commit,
  input  frontend_pkg::br_upd_t     i_br_upd,
  input  logic [31:0]               i_exp_target,
  input  logic                      i_arvalid,
  input  frontend_pkg::axi_ar_t     i_ar,
  input  logic                      i_arready,
  input  logic                      i_rready,
  input  logic                      i_disp_valid,
  input  frontend_pkg::fetch_word_t i_disp,
  input  logic                      i_disp_ready,
  output int                        o_words,
  output int                        o_errors
);

  localparam logic [31:0] INST_XOR = 32'h5a5a_0000;

  logic [31:0] exp_pc;  // next pc the stream must deliver

  // memory map of the bus model, slave error window
  function automatic logic fault_expected(input logic [31:0] pc);
    return (pc >= 32'h0000_3000) && (pc <= 32'h0000_30ff);
  endfunction

  function automatic logic redirect_seen(input frontend_pkg::commit_t c,
                                         input frontend_pkg::br_upd_t b);
    return (c.valid && (c.kind != frontend_pkg::NONE)) || (b.valid && b.mispredict);
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, name, got, expected);
      o_errors++;
    end
  endtask

  // sampled mid-cycle, inputs and outputs are settled here
  always @(negedge i_clk) begin
    if (!i_reset_n) begin
      exp_pc   = frontend_pkg::PC_RESET;
      o_words  = 0;
      o_errors = 0;
    end else begin
      check_field("o_rready", 32'(i_rready), 32'd1);  // always takes read data
      if (i_arvalid && i_arready) begin
        // AxPROT[2] marks an instruction access
        check_field("o_ar.prot[2]", 32'(i_ar.prot[2]), 32'd1);
      end
      if (i_disp_valid && i_disp_ready) begin
        check_field("o_disp.pc", i_disp.pc, exp_pc);
        check_field("o_disp.inst", i_disp.inst, exp_pc ^ INST_XOR);
        check_field("o_disp.fault", 32'(i_disp.fault), 32'(fault_expected(exp_pc)));
        o_words++;
        exp_pc = exp_pc + 32'd4;
      end
      // a handshake in the flush cycle still carries the old word
      if (redirect_seen(i_commit, i_br_upd)) begin
        exp_pc = i_exp_target;
      end
    end
  end

endmodule

// File: tb/tb_frontend.sv
module tb_frontend;

  localparam int          NUM_TESTS = 11;
  localparam logic [31:0] INST_XOR  = 32'h5a5a_0000;

  logic                      i_clk;
  logic                      i_reset_n;
  frontend_pkg::commit_t     i_commit;
  frontend_pkg::br_upd_t     i_br_upd;
  frontend_pkg::csr_vec_t    i_csr;
  logic                      o_arvalid;
  frontend_pkg::axi_ar_t     o_ar;
  logic                      i_arready;
  logic                      i_rvalid;
  frontend_pkg::axi_r_t      i_r;
  logic                      o_rready;
  logic                      o_disp_valid;
  frontend_pkg::fetch_word_t o_disp;
  logic                      i_disp_ready;

  // ====================
  // stimulus table
  // ====================
  string                  t_name   [NUM_TESTS];
  int                     t_wait   [NUM_TESTS];
  frontend_pkg::commit_t  t_commit [NUM_TESTS];
  frontend_pkg::br_upd_t  t_br     [NUM_TESTS];
  frontend_pkg::csr_vec_t t_csr    [NUM_TESTS];
  logic [31:0]            t_target [NUM_TESTS];
  int                     t_words  [NUM_TESTS];
  int                     n_rows = 0;

  logic [31:0] exp_target;
  int          words_seen;
  int          errors_seen;
  logic [31:0] ar_q [$];  // accepted read addresses, oldest first

  frontend_top u_dut (.*);

  frontend_checker u_checker (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_commit     (i_commit),
    .i_br_upd     (i_br_upd),
    .i_exp_target (exp_target),
    .i_arvalid    (o_arvalid),
    .i_ar         (o_ar),
    .i_arready    (i_arready),
    .i_rready     (o_rready),
    .i_disp_valid (o_disp_valid),
    .i_disp       (o_disp),
    .i_disp_ready (i_disp_ready),
    .o_words      (words_seen),
    .o_errors     (errors_seen)
  );

  initial i_clk = 1'b0;
  always #4 i_clk = ~i_clk;

  task automatic step_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic add_row(input string name, input int wait_cycles,
                         input frontend_pkg::commit_kind_e kind, input frontend_pkg::xret_e xret,
                         input logic [3:0] cause, input logic [31:0] epc,
                         input logic br_valid, input logic br_mis, input logic [31:0] br_target,
                         input logic [31:0] mtvec, input logic [15:0] medeleg,
                         input logic [31:0] target, input int words);
    t_name[n_rows]            = name;
    t_wait[n_rows]            = wait_cycles;
    t_commit[n_rows].valid    = (kind != frontend_pkg::NONE);
    t_commit[n_rows].kind     = kind;
    t_commit[n_rows].xret     = xret;
    t_commit[n_rows].cause    = cause;
    t_commit[n_rows].epc      = epc;
    t_br[n_rows].valid        = br_valid;
    t_br[n_rows].mispredict   = br_mis;
    t_br[n_rows].target       = br_target;
    t_csr[n_rows].mepc        = 32'h0000_2802;
    t_csr[n_rows].sepc        = 32'h0000_2c01;
    t_csr[n_rows].mtvec       = mtvec;
    t_csr[n_rows].stvec       = 32'h0000_2e01;  // vectored mode bit set
    t_csr[n_rows].medeleg     = medeleg;
    t_target[n_rows]          = target;
    t_words[n_rows]           = words;
    n_rows++;
  endtask

  task automatic build_table();
    add_row("reset_stream", 0, frontend_pkg::NONE, frontend_pkg::MRET, 4'd0,
            32'h0, 1'b0, 1'b0, 32'h0, 32'h2f00, 16'h0100, frontend_pkg::PC_RESET, 8);
    add_row("branch_mispredict", 3, frontend_pkg::NONE, frontend_pkg::MRET, 4'd0,
            32'h0, 1'b1, 1'b1, 32'h2000, 32'h2f00, 16'h0100, 32'h0000_2000, 6);
    add_row("branch_no_mispredict", 2, frontend_pkg::NONE, frontend_pkg::MRET, 4'd0,
            32'h0, 1'b1, 1'b0, 32'h5000, 32'h2f00, 16'h0100, 32'h0, 6);
    add_row("silent_flush", 4, frontend_pkg::SILENT_FLUSH, frontend_pkg::MRET, 4'd0,
            32'h2403, 1'b0, 1'b0, 32'h0, 32'h2f00, 16'h0100, 32'h0000_2404, 5);
    add_row("mret", 1, frontend_pkg::XRET, frontend_pkg::MRET, 4'd0,
            32'h1234, 1'b0, 1'b0, 32'h0, 32'h2f00, 16'h0100, 32'h0000_2800, 5);
    add_row("sret", 2, frontend_pkg::XRET, frontend_pkg::SRET, 4'd0,
            32'h1234, 1'b0, 1'b0, 32'h0, 32'h2f00, 16'h0100, 32'h0000_2c00, 5);
    // ecall from U, delegated by medeleg bit 8
    add_row("exception_delegated", 3, frontend_pkg::EXCEPTION, frontend_pkg::MRET, 4'd8,
            32'h1234, 1'b0, 1'b0, 32'h0, 32'h2f00, 16'h0100, 32'h0000_2e00, 5);
    add_row("exception_machine", 1, frontend_pkg::EXCEPTION, frontend_pkg::MRET, 4'd2,
            32'h1234, 1'b0, 1'b0, 32'h0, 32'h2f00, 16'h0100, 32'h0000_2f00, 5);
    add_row("commit_beats_branch", 2, frontend_pkg::EXCEPTION, frontend_pkg::MRET, 4'd8,
            32'h1234, 1'b1, 1'b1, 32'h2000, 32'h2f41, 16'h0000, 32'h0000_2f40, 5);
    add_row("random_stalls", 0, frontend_pkg::NONE, frontend_pkg::MRET, 4'd0,
            32'h0, 1'b0, 1'b0, 32'h0, 32'h2f00, 16'h0100, 32'h0, 40);
    add_row("fault_range", 2, frontend_pkg::NONE, frontend_pkg::MRET, 4'd0,
            32'h0, 1'b1, 1'b1, 32'h30f0, 32'h2f00, 16'h0100, 32'h0000_30f0, 8);
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge i_clk);
    $display("watchdog expired before all tests finished");
    $display("Test failed");
    $finish;
  endtask

  // ====================
  // AXI read slave and dispatch stalls
  // ====================
  initial begin
    logic        ar_hs;
    logic        r_hs;
    logic [31:0] ar_addr;
    void'($urandom(32'h2eeb));
    i_arready    = 1'b0;
    i_rvalid     = 1'b0;
    i_r          = '0;
    i_disp_ready = 1'b0;
    forever begin
      @(negedge i_clk);
      ar_hs   = o_arvalid && i_arready;
      ar_addr = o_ar.addr;
      r_hs    = i_rvalid && o_rready;
      step_cycle();
      if (r_hs) begin
        void'(ar_q.pop_front());
      end
      if (ar_hs) begin
        ar_q.push_back(ar_addr);
      end
      i_arready    = ($urandom % 4) != 0;
      i_disp_ready = ($urandom % 4) != 0;
      if (r_hs || !i_rvalid) begin
        if ((ar_q.size() > 0) && (($urandom % 3) != 0)) begin
          i_rvalid = 1'b1;
          i_r.data = ar_q[0] ^ INST_XOR;
          i_r.resp = ((ar_q[0] >= 32'h3000) && (ar_q[0] <= 32'h30ff)) ? 2'b10 : 2'b00;
        end else begin
          i_rvalid = 1'b0;
        end
      end
    end
  end

  // ====================
  // main sequence
  // ====================
  initial begin
    int limit;
    int err_before;
    int words_before;
    int tests_failed;
    int assert_fails;
    i_reset_n  = 1'b0;
    i_commit   = '0;
    i_br_upd   = '0;
    i_csr      = '0;
    exp_target = frontend_pkg::PC_RESET;
    build_table();
    limit = 200;
    for (int i = 0; i < n_rows; i++) begin
      limit += t_wait[i] + 40 * t_words[i];
    end
    fork
      watchdog(limit);
    join_none
    repeat (2) @(posedge i_clk);
    #1;
    i_reset_n    = 1'b1;
    tests_failed = 0;
    for (int i = 0; i < n_rows; i++) begin
      err_before = errors_seen;
      repeat (t_wait[i]) step_cycle();
      exp_target = t_target[i];
      i_commit   = t_commit[i];
      i_br_upd   = t_br[i];
      i_csr      = t_csr[i];
      step_cycle();  // one-cycle pulse
      i_commit     = '0;
      i_br_upd     = '0;
      i_csr        = '0;
      words_before = words_seen;
      while (words_seen < words_before + t_words[i]) begin
        step_cycle();
      end
      if (errors_seen != err_before) begin
        tests_failed++;
      end
      $display("test %0d %s: %0d words, %0d errors", i, t_name[i], t_words[i],
               errors_seen - err_before);
    end
    assert_fails = u_dut.u_fetch_axi_master.u_asserts.n_fail;
    $display("%0d tests passed, %0d tests failed, %0d words checked, %0d assertion failures",
             n_rows - tests_failed, tests_failed, words_seen, assert_fails);
    if ((tests_failed == 0) && (assert_fails == 0)) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: src.f
src/frontend_pkg.sv
src/redirect_target.sv
src/fetch_pc_ctrl.sv
src/fetch_axi_master.sv
src/inst_buffer.sv
src/frontend_top.sv
tb/frontend_asserts.sv
tb/frontend_checker.sv
tb/tb_frontend.sv
